// File: hdl/decode_pkg.sv
// Shared instruction format, opcodes, unit codes and decode bus for the decode slice
`default_nettype none

package decode_pkg;

	// ============================================================
	// Instruction format
	// ============================================================

	// Register specifier, 64 architectural registers
	typedef logic [5:0] reg_t;

	// Register form of the low field with rb in bits 12 to 7
	typedef struct packed {
		reg_t       rb;
		logic [6:0] spare;
	} rb_field_t;

	// The low 13 bits are either rb or a 13-bit immediate
	typedef union packed {
		rb_field_t   r;
		logic [12:0] imm13;
	} low_field_t;

	// Opcode is kept as raw bits so that illegal codes can be carried
	typedef struct packed {
		logic [6:0] opcode;
		reg_t       rt;
		reg_t       ra;
		low_field_t low;
	} instr_t;

	// ============================================================
	// Encodings
	// ============================================================

	// Every code not listed here decodes as illegal
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd1,
		OP_SUB   = 7'd2,
		OP_AND   = 7'd3,
		OP_OR    = 7'd4,
		OP_ADDI  = 7'd5,
		OP_MUL   = 7'd6,
		OP_DIV   = 7'd7,
		OP_LOAD  = 7'd8,
		OP_STORE = 7'd9,
		OP_BEQ   = 7'd10,
		OP_BNE   = 7'd11
	} opcode_e;

	// Target unit on the issue side; UNIT_EXC takes illegal instructions
	typedef enum logic [2:0] {
		UNIT_ALU    = 3'd0,
		UNIT_MULDIV = 3'd1,
		UNIT_MEM    = 3'd2,
		UNIT_BRANCH = 3'd3,
		UNIT_EXC    = 3'd4
	} unit_e;

	// Decode bus carried from the decoder through the queue to dispatch
	typedef struct packed {
		opcode_e     opcode;
		reg_t        rt;
		reg_t        ra;
		reg_t        rb;
		logic [31:0] imm;
		logic        has_imm;
		unit_e       unit;
		logic        alu;
		logic        muldiv;
		logic        load;
		logic        store;
		logic        mem;
		logic        branch;
		logic        backbr;
		logic        nop;
		logic        illegal;
		logic        multicycle;
	} decode_bus_t;

endpackage

`default_nettype wire

// File: hdl/fetch_stage.sv
// Producer stage that accepts instructions against a credit count for the decode queue
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter int DEPTH = 4
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   in_valid,
	input  decode_pkg::instr_t    in_instr,
	input  wire                   credit_return,
	output logic                  in_ready,
	output logic                  dec_en,
	output decode_pkg::instr_t    dec_instr
);

	// The counter has to hold the full value DEPTH right after reset
	localparam int CW = $clog2(DEPTH + 1);

	logic [CW-1:0] credits;
	logic          accept;

	// Each credit stands for one free slot in the decode queue,
	// counting instructions still in flight through the decoder
	assign in_ready = (credits != '0);
	assign accept   = in_valid & in_ready;

	// The decoder samples the instruction on the same edge as the accept
	assign dec_en    = accept;
	assign dec_instr = in_instr;

	// ============================================================
	// Credit counter
	// ============================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= CW'(DEPTH);
		end else begin
			case ({accept, credit_return})
				// Take one credit for the accepted instruction
				2'b10: credits <= credits - 1'b1;
				// The queue freed a slot
				2'b01: credits <= credits + 1'b1;
				// Take and return in one cycle cancel out
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
// Registered instruction decoder that turns one fetched instruction into a decode bus
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     en,
	input  decode_pkg::instr_t      instr,
	output logic                    dbo_valid,
	output decode_pkg::decode_bus_t dbo
);

	import decode_pkg::*;

	decode_bus_t db;
	logic [31:0] imm_sext;

	// All immediate forms share one sign-extended 13-bit field
	assign imm_sext = {{19{instr.low.imm13[12]}}, instr.low.imm13};

	// ============================================================
	// Combinational decode
	// ============================================================

	always_comb begin
		// Start from a clean bus so each opcode only sets what it needs
		db         = '0;
		db.opcode  = opcode_e'(instr.opcode);
		db.rt      = instr.rt;
		db.ra      = instr.ra;
		db.unit    = UNIT_ALU;

		case (instr.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR: begin
				db.alu = 1'b1;
				db.rb  = instr.low.r.rb;
			end
			OP_ADDI: begin
				db.alu     = 1'b1;
				db.has_imm = 1'b1;
				db.imm     = imm_sext;
			end
			// Multiply and divide take several cycles in their unit
			OP_MUL, OP_DIV: begin
				db.unit       = UNIT_MULDIV;
				db.muldiv     = 1'b1;
				db.multicycle = 1'b1;
				db.rb         = instr.low.r.rb;
			end
			// Address is ra plus the immediate for both memory forms
			OP_LOAD: begin
				db.unit    = UNIT_MEM;
				db.has_imm = 1'b1;
				db.imm     = imm_sext;
				db.load    = 1'b1;
				db.mem     = 1'b1;
			end
			// Here rt names the register holding the store data
			OP_STORE: begin
				db.unit    = UNIT_MEM;
				db.has_imm = 1'b1;
				db.imm     = imm_sext;
				db.store   = 1'b1;
				db.mem     = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				db.unit    = UNIT_BRANCH;
				db.branch  = 1'b1;
				db.has_imm = 1'b1;
				db.imm     = imm_sext;
				// A negative displacement marks a backward branch
				db.backbr  = instr.low.imm13[12];
			end
			OP_NOP: begin
				db.nop = 1'b1;
				db.rt  = '0;
				db.ra  = '0;
			end
			default: begin
				db.unit    = UNIT_EXC;
				db.illegal = 1'b1;
			end
		endcase
	end

	// ============================================================
	// Output registers
	// ============================================================

	// Bus payload only loads on an accepted instruction
	always_ff @(posedge clk) begin
		if (en) begin
			dbo <= db;
		end
	end

	// Valid trails the accept by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dbo_valid <= 1'b0;
		end else begin
			dbo_valid <= en;
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_queue.sv
// Circular FIFO of decode buses that returns one fetch credit for every entry removed
`timescale 1ns/1ps
`default_nettype none

module decode_queue #(
	parameter int DEPTH = 4
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     push,
	input  decode_pkg::decode_bus_t push_bus,
	input  wire                     pop,
	output logic                    head_valid,
	output decode_pkg::decode_bus_t head_bus,
	output logic                    credit_return
);

	import decode_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	decode_bus_t   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_pop;

	// Head is read straight out of the array
	assign head_valid = (count != '0);
	assign head_bus   = mem[rd_ptr];

	// A pop request on an empty queue is ignored
	assign do_pop        = pop & head_valid;
	assign credit_return = do_pop;

	// Storage write; the credit scheme keeps pushes off a full queue
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_bus;
		end
	end

	// ============================================================
	// Pointers and occupancy
	// ============================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Explicit wrap so that DEPTH need not be a power of two
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/dispatch_stage.sv
// Consumer stage that drops nops and puts every other queued instruction on the issue port
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
	input  wire                     head_valid,
	input  decode_pkg::decode_bus_t head_bus,
	input  wire                     issue_ready,
	output logic                    pop,
	output logic                    issue_valid,
	output decode_pkg::unit_e       issue_unit,
	output decode_pkg::opcode_e     issue_opcode,
	output decode_pkg::reg_t        issue_rt,
	output decode_pkg::reg_t        issue_ra,
	output decode_pkg::reg_t        issue_rb,
	output logic [31:0]             issue_imm,
	output logic                    issue_has_imm,
	output logic                    issue_load,
	output logic                    issue_store,
	output logic                    issue_backbr,
	output logic                    issue_multicycle
);

	logic head_nop;

	assign head_nop = head_bus.nop;

	// ============================================================
	// Issue handshake
	// ============================================================

	// Nops never reach the execution side
	assign issue_valid = head_valid & ~head_nop;

	// A nop leaves at once, anything else waits for the execution side
	assign pop = head_valid & (head_nop | issue_ready);

	// ============================================================
	// Issue payload
	// ============================================================

	// Fields pass through from the head entry unchanged
	assign issue_unit       = head_bus.unit;
	assign issue_opcode     = head_bus.opcode;
	assign issue_rt         = head_bus.rt;
	assign issue_ra         = head_bus.ra;
	assign issue_rb         = head_bus.rb;
	assign issue_imm        = head_bus.imm;
	assign issue_has_imm    = head_bus.has_imm;
	assign issue_load       = head_bus.load;
	assign issue_store      = head_bus.store;
	assign issue_backbr     = head_bus.backbr;
	assign issue_multicycle = head_bus.multicycle;

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
// Top level of the decode slice; connects fetch, decoder, queue and dispatch and sets the depth
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
	parameter int DEPTH = 4
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     in_valid,
	input  decode_pkg::instr_t      in_instr,
	output logic                    in_ready,
	output logic                    issue_valid,
	output decode_pkg::unit_e       issue_unit,
	output decode_pkg::opcode_e     issue_opcode,
	output decode_pkg::reg_t        issue_rt,
	output decode_pkg::reg_t        issue_ra,
	output decode_pkg::reg_t        issue_rb,
	output logic [31:0]             issue_imm,
	output logic                    issue_has_imm,
	output logic                    issue_load,
	output logic                    issue_store,
	output logic                    issue_backbr,
	output logic                    issue_multicycle,
	input  wire                     issue_ready
);

	import decode_pkg::*;

	logic        dec_en;
	instr_t      dec_instr;
	logic        dec_valid;
	decode_bus_t dec_bus;
	logic        credit_return;
	logic        head_valid;
	decode_bus_t head_bus;
	logic        pop;

	// ============================================================
	// Stages
	// ============================================================

	// Credits start at DEPTH so fetch never overruns the queue
	fetch_stage #(
		.DEPTH(DEPTH)
	) u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.credit_return(credit_return),
		.in_ready     (in_ready),
		.dec_en       (dec_en),
		.dec_instr    (dec_instr)
	);

	instr_decoder u_decoder (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (dec_en),
		.instr    (dec_instr),
		.dbo_valid(dec_valid),
		.dbo      (dec_bus)
	);

	// Every valid decode bus is pushed on the following edge
	decode_queue #(
		.DEPTH(DEPTH)
	) u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.push         (dec_valid),
		.push_bus     (dec_bus),
		.pop          (pop),
		.head_valid   (head_valid),
		.head_bus     (head_bus),
		.credit_return(credit_return)
	);

	dispatch_stage u_dispatch (
		.head_valid      (head_valid),
		.head_bus        (head_bus),
		.issue_ready     (issue_ready),
		.pop             (pop),
		.issue_valid     (issue_valid),
		.issue_unit      (issue_unit),
		.issue_opcode    (issue_opcode),
		.issue_rt        (issue_rt),
		.issue_ra        (issue_ra),
		.issue_rb        (issue_rb),
		.issue_imm       (issue_imm),
		.issue_has_imm   (issue_has_imm),
		.issue_load      (issue_load),
		.issue_store     (issue_store),
		.issue_backbr    (issue_backbr),
		.issue_multicycle(issue_multicycle)
	);

endmodule

`default_nettype wire

// File: tests/decode_asserts.sv
// Concurrent checks on occupancy and credit return that are bound into every decode_queue
`timescale 1ns/1ps
`default_nettype none

module decode_queue_asserts #(
	parameter int DEPTH = 4
) (
	input wire                       clk,
	input wire                       rst_n,
	input wire                       push,
	input wire                       pop,
	input wire                       credit_return,
	input wire [$clog2(DEPTH+1)-1:0] count
);

	// Count of failed checks that the testbench reads when the run ends
	int violations = 0;

	// ============================================================
	// Queue rules
	// ============================================================

	// The credit scheme must keep the decoder from writing a full queue
	assert property (@(posedge clk) disable iff (!rst_n) !(push && count == DEPTH))
	else begin
		violations++;
		$error("Push into a full decode queue");
	end

	// Dispatch only asks for a pop while an entry is present
	assert property (@(posedge clk) disable iff (!rst_n) !(pop && count == '0))
	else begin
		violations++;
		$error("Pop from an empty decode queue");
	end

	// A credit goes back only for an entry that really leaves the queue
	assert property (@(posedge clk) disable iff (!rst_n)
		credit_return |=> count == $past(count) - 1'b1 + $past(push))
	else begin
		violations++;
		$error("Credit returned without an entry leaving the queue");
	end

endmodule

bind decode_queue decode_queue_asserts #(
	.DEPTH(DEPTH)
) u_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.push         (push),
	.pop          (pop),
	.credit_return(credit_return),
	.count        (count)
);

`default_nettype wire

// File: tests/decode_tb.sv
// Directed testbench for the decode slice; compile the sources in vlog.f and run decode_tb as top
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

	import decode_pkg::*;

	localparam int DEPTH = 4;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	instr_t      in_instr;
	logic        in_ready;
	logic        issue_valid;
	unit_e       issue_unit;
	opcode_e     issue_opcode;
	reg_t        issue_rt;
	reg_t        issue_ra;
	reg_t        issue_rb;
	logic [31:0] issue_imm;
	logic        issue_has_imm;
	logic        issue_load;
	logic        issue_store;
	logic        issue_backbr;
	logic        issue_multicycle;
	logic        issue_ready;

	// Expected issue records in program order without any nops
	decode_bus_t expq[$];
	int          seed;
	int          issued;
	unit_e       last_unit;

	decode_top #(
		.DEPTH(DEPTH)
	) DUT (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_instr(in_instr),
		.in_ready(in_ready), .issue_valid(issue_valid), .issue_unit(issue_unit),
		.issue_opcode(issue_opcode), .issue_rt(issue_rt), .issue_ra(issue_ra),
		.issue_rb(issue_rb), .issue_imm(issue_imm), .issue_has_imm(issue_has_imm),
		.issue_load(issue_load), .issue_store(issue_store), .issue_backbr(issue_backbr),
		.issue_multicycle(issue_multicycle), .issue_ready(issue_ready)
	);

	always #2 clk = ~clk;

	// ============================================================
	// Reference decode and helpers
	// ============================================================

	function automatic instr_t make_instr(input logic [6:0] op, input reg_t rt,
		input reg_t ra, input logic [12:0] low);
		make_instr = {op, rt, ra, low};
	endfunction

	// Decode rule written from the opcode table and applied by opcode ranges
	function automatic decode_bus_t ref_decode(input instr_t ins);
		decode_bus_t e;
		int          op;
		int          simm;
		e        = '0;
		op       = int'(ins.opcode);
		simm     = $signed(ins.low.imm13);
		e.opcode = opcode_e'(ins.opcode);
		e.rt     = ins.rt;
		e.ra     = ins.ra;
		e.unit   = UNIT_ALU;
		if (op == 0) begin
			e.nop = 1'b1;
			e.rt  = '0;
			e.ra  = '0;
		end else if (op <= 4) begin
			e.alu = 1'b1;
			e.rb  = ins[12:7];
		end else if (op == 5) begin
			e.alu     = 1'b1;
			e.has_imm = 1'b1;
			e.imm     = simm;
		end else if (op <= 7) begin
			e.unit       = UNIT_MULDIV;
			e.muldiv     = 1'b1;
			e.multicycle = 1'b1;
			e.rb         = ins[12:7];
		end else if (op <= 9) begin
			// Loads and stores share the address form and rt is data for a store
			e.unit    = UNIT_MEM;
			e.mem     = 1'b1;
			e.has_imm = 1'b1;
			e.imm     = simm;
			e.load    = (op == 8);
			e.store   = (op == 9);
		end else if (op <= 11) begin
			e.unit    = UNIT_BRANCH;
			e.branch  = 1'b1;
			e.has_imm = 1'b1;
			e.imm     = simm;
			e.backbr  = (simm < 0);
		end else begin
			e.unit    = UNIT_EXC;
			e.illegal = 1'b1;
		end
		ref_decode = e;
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			abort_run("A checked value differs from its expected value");
		end
	endtask

	task automatic compare_issue(input decode_bus_t e);
		check_value("issue_unit", issue_unit, e.unit);
		check_value("issue_opcode", issue_opcode, e.opcode);
		check_value("issue_rt", issue_rt, e.rt);
		check_value("issue_ra", issue_ra, e.ra);
		check_value("issue_rb", issue_rb, e.rb);
		check_value("issue_imm", issue_imm, e.imm);
		check_value("issue_has_imm", issue_has_imm, e.has_imm);
		check_value("issue_load", issue_load, e.load);
		check_value("issue_store", issue_store, e.store);
		check_value("issue_backbr", issue_backbr, e.backbr);
		check_value("issue_multicycle", issue_multicycle, e.multicycle);
	endtask

	// Each call is one clock cycle that drives on the falling edge and then looks at what
	// the next rising edge will accept and transfer once the inputs have settled
	task automatic step(input logic v, input instr_t ins, input logic rdy, output logic acc);
		decode_bus_t e;
		@(negedge clk);
		in_valid    = v;
		in_instr    = ins;
		issue_ready = rdy;
		#1;
		acc = in_valid & in_ready;
		if (acc) begin
			e = ref_decode(ins);
			if (!e.nop)
				expq.push_back(e);
		end
		if (issue_valid && issue_ready) begin
			if (expq.size() == 0)
				abort_run("An instruction issued when none was expected");
			else begin
				compare_issue(expq.pop_front());
				last_unit = issue_unit;
				issued++;
			end
		end
	endtask

	task automatic send_instr(input instr_t ins);
		logic acc;
		int   guard;
		acc   = 1'b0;
		guard = 0;
		while (!acc) begin
			if (guard == 20)
				abort_run("Timeout waiting for in_ready to take an instruction");
			else begin
				step(1'b1, ins, 1'b1, acc);
				guard++;
			end
		end
	endtask

	task automatic drain();
		logic acc;
		int   guard;
		guard = 0;
		while (expq.size() != 0) begin
			if (guard == 100)
				abort_run("Timeout waiting for the issue port to drain");
			else begin
				step(1'b0, '0, 1'b1, acc);
				guard++;
			end
		end
		// Trailing nops still have to leave the decoder and the queue
		repeat (4) step(1'b0, '0, 1'b1, acc);
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic opcode_sweep();
		int base;
		base = issued;
		send_instr(make_instr(OP_ADD, 6'd1, 6'd2, {6'd3, 7'd0}));
		send_instr(make_instr(OP_SUB, 6'd63, 6'd10, {6'd62, 7'd0}));
		send_instr(make_instr(OP_AND, 6'd4, 6'd5, {6'd6, 7'd0}));
		send_instr(make_instr(OP_OR, 6'd7, 6'd8, {6'd9, 7'd0}));
		send_instr(make_instr(OP_ADDI, 6'd11, 6'd12, 13'd100));
		send_instr(make_instr(OP_ADDI, 6'd13, 6'd14, 13'h1ffd));
		send_instr(make_instr(OP_MUL, 6'd15, 6'd16, {6'd17, 7'd0}));
		send_instr(make_instr(OP_DIV, 6'd18, 6'd19, {6'd20, 7'd0}));
		send_instr(make_instr(OP_LOAD, 6'd21, 6'd22, 13'd64));
		send_instr(make_instr(OP_STORE, 6'd23, 6'd24, 13'h1ff0));
		send_instr(make_instr(OP_BEQ, 6'd25, 6'd26, 13'd12));
		send_instr(make_instr(OP_BNE, 6'd27, 6'd28, 13'h1000));
		drain();
		check_value("issued count", issued - base, 12);
	endtask

	task automatic nop_filtering();
		int base;
		base = issued;
		send_instr(make_instr(OP_NOP, 6'd0, 6'd0, 13'd0));
		send_instr(make_instr(OP_ADD, 6'd30, 6'd31, {6'd32, 7'd0}));
		send_instr(make_instr(OP_NOP, 6'd5, 6'd5, 13'd5));
		send_instr(make_instr(OP_NOP, 6'd0, 6'd0, 13'd0));
		send_instr(make_instr(OP_SUB, 6'd33, 6'd34, {6'd35, 7'd0}));
		send_instr(make_instr(OP_NOP, 6'd0, 6'd0, 13'd0));
		send_instr(make_instr(OP_LOAD, 6'd36, 6'd37, 13'd8));
		drain();
		check_value("issued count", issued - base, 3);
		check_value("in_ready", in_ready, 1);
	endtask

	task automatic credit_backpressure();
		logic acc;
		int   accepted;
		int   guard;
		int   base;
		acc      = 1'b1;
		accepted = 0;
		guard    = 0;
		base     = issued;
		// Keep offering until the credits run out with the issue side stalled
		while (acc) begin
			if (guard == 20)
				abort_run("Timeout waiting for in_ready to fall under back-pressure");
			else begin
				step(1'b1, make_instr(OP_MUL, reg_t'(guard), 6'd40, {6'd41, 7'd0}), 1'b0, acc);
				if (acc)
					accepted++;
				guard++;
			end
		end
		check_value("accepted count", accepted, DEPTH);
		repeat (3) step(1'b0, '0, 1'b0, acc);
		check_value("in_ready", in_ready, 0);
		check_value("issued count", issued - base, 0);
		drain();
		check_value("issued count", issued - base, DEPTH);
	endtask

	task automatic illegal_opcode();
		int base;
		base = issued;
		send_instr(make_instr(7'd100, 6'd1, 6'd2, 13'd3));
		drain();
		check_value("issued count", issued - base, 1);
		check_value("illegal issue_unit", last_unit, UNIT_EXC);
	endtask

	task automatic random_stream();
		logic   acc;
		logic   v;
		logic   rdy;
		instr_t ins;
		int     sent;
		int     guard;
		sent  = 0;
		guard = 0;
		while (sent < 200) begin
			if (guard == 4000)
				abort_run("Timeout while sending the random instruction stream");
			else begin
				v   = (($random(seed) & 15) < 11);
				rdy = (($random(seed) & 7) < 5);
				ins = make_instr(7'($random(seed) & 15), reg_t'($random(seed)),
					reg_t'($random(seed)), 13'($random(seed)));
				step(v, ins, rdy, acc);
				if (acc)
					sent++;
				guard++;
			end
		end
		drain();
		check_value("queue head_valid", DUT.u_queue.head_valid, 0);
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_instr    = '0;
		issue_ready = 1'b0;
		seed        = 32'hdd47;
		issued      = 0;
		last_unit   = UNIT_ALU;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		#1;
		check_value("issue_valid", issue_valid, 0);
		check_value("in_ready", in_ready, 1);
		opcode_sweep();
		nop_filtering();
		credit_backpressure();
		illegal_opcode();
		random_stream();
		if (DUT.u_queue.u_asserts.violations != 0)
			abort_run("Decode queue assertions reported violations");
		else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/decode_pkg.sv
hdl/fetch_stage.sv
hdl/instr_decoder.sv
hdl/decode_queue.sv
hdl/dispatch_stage.sv
hdl/decode_top.sv
tests/decode_asserts.sv
tests/decode_tb.sv

// File: Bender.yml
package:
  name: decode_slice

sources:
  - files:
      - hdl/decode_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/instr_decoder.sv
      - hdl/decode_queue.sv
      - hdl/dispatch_stage.sv
      - hdl/decode_top.sv
  - target: test
    files:
      - tests/decode_asserts.sv
      - tests/decode_tb.sv
